// ==== sim/dma_vectors.txt ====
# One command per line, fields in hex: D disk_word_index data | W addr data
# R addr expected | T disk_byte_offset mem_byte_addr size_bytes
D 010 11110000
D 011 22220001
D 012 33330002
D 013 44440003
D 020 deadbeef
D 02f 0badcafe
R f00c 00000000
W f000 00000040
R f000 00000040
W f004 00000100
R f004 00000100
W 0010 12345678
R 0010 12345678
W 0014 cafef00d
R 0014 cafef00d
T 040 100 010
T 080 200 040
W f00c 00000000
R f00c 00000000
W 0300 5e5e0000
W 0304 5e5e0001
T 0c0 300 000
R 0300 5e5e0000
R 0304 5e5e0001

// ==== vlog.f ====
common/dma_pkg.sv
dma/dma_line_buffer.sv
dma/dma_bus_controller.sv
src/bus_arbiter.sv
src/bus_memory.sv
src/dma_subsystem.sv
sim/dma_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the DMA subsystem testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module dma_subsystem_tb -f vlog.f -o dma_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/dma_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
   exit 0
else
   exit 1
fi

// ==== sim/dma_subsystem_tb.sv ====
// DMA subsystem testbench with host bus model, disk model, vector reader, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module dma_subsystem_tb
   import dma_pkg::*;
();

   localparam int          ACK_LIMIT    = 32;
   localparam int          GRANT_LIMIT  = 64;
   localparam logic [31:0] SEED         = 32'hdc56f0ed;
   localparam bus_addr_t   TRAFFIC_BASE = 16'h0C00;

   logic               bus_clk;
   logic               reset;
   logic               host_br;
   bus_addr_t          host_a;
   word_t              host_d;
   logic               host_rw;
   logic               host_strobe;
   logic               host_bg;
   logic               bus_ack;
   word_t              bus_rdata;
   word_t              disk_data = '0;
   logic               disk_en;
   logic [DISK_AW-1:0] disk_addr;
   logic               dma_intr;

   word_t disk_model [DISK_WORDS];
   word_t mem_model [MEM_WORDS];
   byte   vec_kind [$];
   word_t vec_a [$];
   word_t vec_b [$];
   word_t vec_c [$];
   int    pass_count;
   int    fail_count;
   int    cycle_count = 0;
   int    cycle_limit = 0;
   logic  test_ok;

   dma_subsystem dma_subsystem_inst (
      .bus_clk     (bus_clk),
      .reset       (reset),
      .host_br     (host_br),
      .host_a      (host_a),
      .host_d      (host_d),
      .host_rw     (host_rw),
      .host_strobe (host_strobe),
      .host_bg     (host_bg),
      .bus_ack     (bus_ack),
      .bus_rdata   (bus_rdata),
      .disk_data   (disk_data),
      .disk_en     (disk_en),
      .disk_addr   (disk_addr),
      .dma_intr    (dma_intr)
   );

   initial begin
      bus_clk = 1'b0;
      forever #2 bus_clk = ~bus_clk;
   end

   // Disk answers one cycle after the read
   always @(posedge bus_clk) begin
      if (disk_en) begin
         disk_data <= disk_model[disk_addr];
      end
   end

   always @(posedge bus_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         abort_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $finish;
   endtask

   function automatic bus_addr_t reg_addr(input logic [3:0] off);
      return {DMA_BASE[15:4], off};
   endfunction

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got === exp) begin
         pass_count++;
      end else begin
         fail_count++;
         test_ok = 1'b0;
         $display("Error at %0d ns: %s was 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input string what, input dma_status_t got,
                               input dma_status_t exp);
      if (got === exp) begin
         pass_count++;
      end else begin
         fail_count++;
         test_ok = 1'b0;
         $display("Error at %0d ns: %s was %s, expected %s", $time, what, got.name(),
                  exp.name());
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got === exp) begin
         pass_count++;
      end else begin
         fail_count++;
         test_ok = 1'b0;
         $display("Error at %0d ns: %s was %b, expected %b", $time, what, got, exp);
      end
   endtask

   // One host beat from bus request through acknowledge to release
   task automatic host_access(input bus_addr_t addr, input word_t wdata, input logic write,
                              output word_t rdata, output logic ok);
      int waited;
      ok    = 1'b0;
      rdata = '0;
      @(posedge bus_clk);
      host_br <= 1'b1;
      host_a  <= addr;
      host_d  <= wdata;
      host_rw <= write;
      waited = 0;
      @(negedge bus_clk);
      while (!host_bg && waited < GRANT_LIMIT) begin
         @(negedge bus_clk);
         waited++;
      end
      if (!host_bg) begin
         fail_count++;
         test_ok = 1'b0;
         $display("Host never got the bus for address 0x%04h", addr);
      end else begin
         @(posedge bus_clk);
         host_strobe <= 1'b1;
         waited = 0;
         @(negedge bus_clk);
         while (!bus_ack && waited < ACK_LIMIT) begin
            @(negedge bus_clk);
            waited++;
         end
         if (bus_ack) begin
            rdata = bus_rdata;
            ok    = 1'b1;
         end else begin
            fail_count++;
            test_ok = 1'b0;
            $display("Timeout: host beat was never acknowledged at address 0x%04h", addr);
         end
      end
      @(posedge bus_clk);
      host_strobe <= 1'b0;
      host_br     <= 1'b0;
      @(negedge bus_clk);
   endtask

   task automatic host_write(input bus_addr_t addr, input word_t value);
      word_t got;
      logic  ok;
      host_access(addr, value, 1'b1, got, ok);
   endtask

   // Random-gap host traffic in a region the DMA never touches
   task automatic run_traffic(output int accesses);
      int        gap;
      bus_addr_t addr;
      word_t     value;
      word_t     got;
      logic      ok;
      accesses = 0;
      while (!dma_intr) begin
         gap = int'($urandom % 4);
         repeat (gap) @(negedge bus_clk);
         addr  = TRAFFIC_BASE + bus_addr_t'(($urandom % 64) * 4);
         value = $urandom;
         host_access(addr, value, 1'b1, got, ok);
         if (ok) mem_model[addr[MEM_AW+1:2]] = value;
         host_access(addr, '0, 1'b0, got, ok);
         if (ok) check_word($sformatf("Traffic read 0x%04h", addr), got,
                            mem_model[addr[MEM_AW+1:2]]);
         accesses += 2;
      end
   endtask

   task automatic run_transfer(input word_t src, input word_t dst, input word_t size,
                               output int accesses);
      word_t              got;
      logic               ok;
      int                 words;
      logic [DISK_AW-1:0] didx;
      logic [MEM_AW-1:0]  midx;
      host_write(reg_addr(REG_SRC), src);
      host_write(reg_addr(REG_DST), dst);
      host_write(reg_addr(REG_CMD), size);
      accesses = 0;
      if (size > LINE_BYTES) run_traffic(accesses);
      while (!dma_intr) @(negedge bus_clk);
      host_access(reg_addr(REG_STAT), '0, 1'b0, got, ok);
      if (ok) check_status("STAT after transfer", dma_status_t'(got[1:0]), STAT_DONE);
      check_bit("dma_intr after transfer", dma_intr, 1'b1);
      // Memory at dst plus i holds disk word at src plus i
      words = int'(size) / 4;
      for (int i = 0; i < words; i++) begin
         didx = DISK_AW'(int'(src) / 4 + i);
         midx = MEM_AW'(int'(dst) / 4 + i);
         mem_model[midx] = disk_model[didx];
         host_access(bus_addr_t'(dst + word_t'(i * 4)), '0, 1'b0, got, ok);
         if (ok) check_word($sformatf("Copied word %0d", i), got, mem_model[midx]);
      end
   endtask

   task automatic run_vector(input int num, input byte kind, input word_t a, input word_t b,
                             input word_t c);
      word_t got;
      logic  ok;
      int    accesses;
      string desc;
      test_ok = 1'b1;
      case (kind)
         "W": begin
            host_write(bus_addr_t'(a), b);
            if (a < 32'h1000) mem_model[a[MEM_AW+1:2]] = b;
            desc = $sformatf("write 0x%04h = 0x%08h", a[15:0], b);
         end
         "R": begin
            host_access(bus_addr_t'(a), '0, 1'b0, got, ok);
            if (ok && bus_addr_t'(a) == reg_addr(REG_STAT)) begin
               check_status("STAT", dma_status_t'(got[1:0]), dma_status_t'(b[1:0]));
               check_bit("dma_intr", dma_intr, b[1:0] == STAT_DONE);
            end else if (ok) begin
               check_word($sformatf("Read 0x%04h", a[15:0]), got, b);
            end
            desc = $sformatf("read 0x%04h", a[15:0]);
         end
         "T": begin
            run_transfer(a, b, c, accesses);
            desc = $sformatf("transfer 0x%03h bytes to 0x%04h, %0d host beats alongside",
                             c[11:0], b[15:0], accesses);
         end
         default: begin
            fail_count++;
            test_ok = 1'b0;
            desc = $sformatf("unknown vector kind %c", kind);
         end
      endcase
      $display("Test %0d %s: %s", num, desc, test_ok ? "ok" : "FAILED");
   endtask

   // Disk entries go straight into the disk model and commands are queued
   task automatic load_vectors();
      int    fd;
      int    lines;
      int    bytes;
      byte   kind;
      string line;
      word_t a;
      word_t b;
      word_t c;
      fd = $fopen("sim/dma_vectors.txt", "r");
      if (fd == 0) begin
         abort_run("Could not open sim/dma_vectors.txt");
      end else begin
         lines = 0;
         bytes = 0;
         while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (line.len() > 1 && kind != "#") begin
               a = '0;
               b = '0;
               c = '0;
               void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
               lines++;
               if (kind == "D") begin
                  disk_model[a[DISK_AW-1:0]] = b;
               end else begin
                  vec_kind.push_back(kind);
                  vec_a.push_back(a);
                  vec_b.push_back(b);
                  vec_c.push_back(c);
               end
               if (kind == "T") bytes += int'(c);
            end
         end
         $fclose(fd);
         cycle_limit = 64 * lines + 16 * bytes;
      end
   endtask

   initial begin
      reset       = 1'b1;
      host_br     = 1'b0;
      host_a      = '0;
      host_d      = '0;
      host_rw     = 1'b0;
      host_strobe = 1'b0;
      pass_count  = 0;
      fail_count  = 0;
      void'($urandom(SEED));
      for (int i = 0; i < DISK_WORDS; i++) begin
         disk_model[DISK_AW'(i)] = 32'h5a5a_0000 ^ (word_t'(i) * 32'h0001_0001);
         mem_model[MEM_AW'(i)]   = '0;
      end
      load_vectors();

      repeat (3) @(posedge bus_clk);
      reset <= 1'b0;
      @(negedge bus_clk);
      test_ok = 1'b1;
      check_bit("host_bg after reset", host_bg, 1'b0);
      check_bit("bus_ack after reset", bus_ack, 1'b0);
      check_bit("disk_en after reset", disk_en, 1'b0);
      check_bit("dma_intr after reset", dma_intr, 1'b0);
      $display("Test 0 reset outputs: %s", test_ok ? "ok" : "FAILED");

      for (int i = 0; i < vec_kind.size(); i++) begin
         run_vector(i + 1, vec_kind[i], vec_a[i], vec_b[i], vec_c[i]);
      end

      $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/dma_subsystem.sv ====
// DMA subsystem top: controller, line buffer, arbiter, memory and the shared bus mux
`timescale 1ns/1ps
`default_nettype none

module dma_subsystem
   import dma_pkg::*;
(
   input  logic               bus_clk,
   input  logic               reset,
   // Host master
   input  logic               host_br,
   input  bus_addr_t          host_a,
   input  word_t              host_d,
   input  logic               host_rw,
   input  logic               host_strobe,
   output logic               host_bg,
   output logic               bus_ack,
   output word_t              bus_rdata,
   // Disk
   input  word_t              disk_data,
   output logic               disk_en,
   output logic [DISK_AW-1:0] disk_addr,
   output logic               dma_intr
);

   bus_addr_t         bus_a;
   word_t             bus_d;
   logic              bus_rw;
   logic              bus_strobe;
   logic              dma_bg;
   logic              dma_br;
   bus_addr_t         dma_a;
   word_t             dma_d;
   logic              dma_rw;
   logic              dma_strobe;
   logic              slave_ack;
   word_t             slave_rdata;
   logic              mem_ack;
   word_t             mem_rdata;
   logic              buf_load;
   logic [BEAT_W-1:0] buf_beat;
   word_t             buf_word;

   // Owner drives the bus, nobody strobes without a grant
   always_comb begin
      if (dma_bg) begin
         bus_a      = dma_a;
         bus_d      = dma_d;
         bus_rw     = dma_rw;
         bus_strobe = dma_strobe;
      end else if (host_bg) begin
         bus_a      = host_a;
         bus_d      = host_d;
         bus_rw     = host_rw;
         bus_strobe = host_strobe;
      end else begin
         bus_a      = '0;
         bus_d      = '0;
         bus_rw     = 1'b0;
         bus_strobe = 1'b0;
      end
   end

   // Read data from whichever slave is acking
   assign bus_ack   = mem_ack | slave_ack;
   assign bus_rdata = slave_ack ? slave_rdata : (mem_ack ? mem_rdata : '0);

   dma_bus_controller dma_bus_controller_inst (
      .bus_clk     (bus_clk),
      .reset       (reset),
      .bus_a       (bus_a),
      .bus_d       (bus_d),
      .bus_rw      (bus_rw),
      .bus_strobe  (bus_strobe),
      .slave_ack   (slave_ack),
      .slave_rdata (slave_rdata),
      .dma_bg      (dma_bg),
      .bus_ack     (bus_ack),
      .dma_br      (dma_br),
      .dma_a       (dma_a),
      .dma_d       (dma_d),
      .dma_rw      (dma_rw),
      .dma_strobe  (dma_strobe),
      .disk_en     (disk_en),
      .disk_addr   (disk_addr),
      .buf_word    (buf_word),
      .buf_load    (buf_load),
      .buf_beat    (buf_beat),
      .dma_intr    (dma_intr)
   );

   dma_line_buffer dma_line_buffer_inst (
      .bus_clk   (bus_clk),
      .reset     (reset),
      .disk_data (disk_data),
      .buf_load  (buf_load),
      .buf_beat  (buf_beat),
      .buf_word  (buf_word)
   );

   bus_arbiter bus_arbiter_inst (
      .bus_clk (bus_clk),
      .reset   (reset),
      .host_br (host_br),
      .dma_br  (dma_br),
      .host_bg (host_bg),
      .dma_bg  (dma_bg)
   );

   bus_memory bus_memory_inst (
      .bus_clk    (bus_clk),
      .reset      (reset),
      .bus_a      (bus_a),
      .bus_d      (bus_d),
      .bus_rw     (bus_rw),
      .bus_strobe (bus_strobe),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== src/bus_memory.sv ====
// Word-addressed memory slave on the shared bus, one-cycle registered acknowledge
`timescale 1ns/1ps
`default_nettype none

module bus_memory
   import dma_pkg::*;
(
   input  logic      bus_clk,
   input  logic      reset,
   input  bus_addr_t bus_a,
   input  word_t     bus_d,
   input  logic      bus_rw,
   input  logic      bus_strobe,
   output logic      mem_ack,
   output word_t     mem_rdata
);

   word_t             mem [MEM_WORDS];
   logic [MEM_AW-1:0] word_idx;
   logic              in_range;
   logic              take;

   // Only the low 4 KB belong to memory
   assign in_range = bus_a[15:MEM_AW+2] == '0;
   assign word_idx = bus_a[MEM_AW+1:2];

   // No new beat while the previous ack is out
   assign take = bus_strobe && in_range && !mem_ack;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         mem_ack <= 1'b0;
      end else begin
         mem_ack <= take;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (take) begin
         if (bus_rw) begin
            mem[word_idx] <= bus_d;
         end
         mem_rdata <= mem[word_idx];
      end
   end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
// Two-master round-robin bus arbiter with held ownership
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
   input  logic bus_clk,
   input  logic reset,
   input  logic host_br,
   input  logic dma_br,
   output logic host_bg,
   output logic dma_bg
);

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_HOST,
      OWN_DMA
   } owner_t;

   owner_t owner;
   logic   last_dma;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         owner    <= OWN_NONE;
         last_dma <= 1'b0;
      end else begin
         case (owner)
            // Grants only leave the free state
            OWN_NONE: begin
               if (host_br && dma_br) begin
                  owner    <= last_dma ? OWN_HOST : OWN_DMA;
                  last_dma <= !last_dma;
               end else if (host_br) begin
                  owner    <= OWN_HOST;
                  last_dma <= 1'b0;
               end else if (dma_br) begin
                  owner    <= OWN_DMA;
                  last_dma <= 1'b1;
               end
            end
            // Release costs one idle cycle
            OWN_HOST: begin
               if (!host_br) begin
                  owner <= OWN_NONE;
               end
            end
            OWN_DMA: begin
               if (!dma_br) begin
                  owner <= OWN_NONE;
               end
            end
            default: owner <= OWN_NONE;
         endcase
      end
   end

   // Grant falls together with the request
   assign host_bg = (owner == OWN_HOST) && host_br;
   assign dma_bg  = (owner == OWN_DMA) && dma_br;

endmodule

`default_nettype wire

// ==== dma/dma_bus_controller.sv ====
// DMA bus controller: FSM, register slave, byte count, disk and memory address counters
`timescale 1ns/1ps
`default_nettype none

module dma_bus_controller
   import dma_pkg::*;
(
   input  logic               bus_clk,
   input  logic               reset,
   // Shared bus, seen as a slave
   input  bus_addr_t          bus_a,
   input  word_t              bus_d,
   input  logic               bus_rw,
   input  logic               bus_strobe,
   output logic               slave_ack,
   output word_t              slave_rdata,
   // Master side
   input  logic               dma_bg,
   input  logic               bus_ack,
   output logic               dma_br,
   output bus_addr_t          dma_a,
   output word_t              dma_d,
   output logic               dma_rw,
   output logic               dma_strobe,
   // Disk read port
   output logic               disk_en,
   output logic [DISK_AW-1:0] disk_addr,
   // Line buffer control
   input  word_t              buf_word,
   output logic               buf_load,
   output logic [BEAT_W-1:0]  buf_beat,
   output logic               dma_intr
);

   dma_state_t          state;
   dma_state_t          state_next;
   dma_status_t         stat_q;
   dma_size_t           count_q;
   dma_size_t           count_next;
   dma_size_t           cmd_size;
   bus_addr_t           src_q;
   bus_addr_t           dst_q;
   logic [BEAT_W-1:0]   fill_cnt;
   logic [BEAT_W-1:0]   beat_cnt;
   logic [BEAT_W-1:0]   load_idx;
   logic                load_q;
   logic [3:0]          reg_off;
   logic                reg_hit;
   logic                reg_take;
   logic                reg_wr;
   logic                prog_ok;
   logic                cmd_wr;
   logic                stat_wr;
   logic                last_beat;
   logic                line_end;

   // Register window decode, one beat at a time
   assign reg_hit  = bus_a[15:4] == DMA_BASE[15:4];
   assign reg_off  = bus_a[3:0];
   assign reg_take = bus_strobe && reg_hit && !slave_ack;
   assign reg_wr   = reg_take && bus_rw;

   // Programming is accepted whenever no transfer is running
   assign prog_ok  = (state == IDLE) || (state == DONE);
   assign cmd_wr   = reg_wr && (reg_off == REG_CMD) && prog_ok;
   assign stat_wr  = reg_wr && (reg_off == REG_STAT);
   assign cmd_size = bus_d[11:0];

   assign last_beat  = beat_cnt == BEAT_W'(LINE_BEATS - 1);
   assign line_end   = (state == ST_WR) && bus_ack && last_beat;
   assign count_next = count_q - dma_size_t'(LINE_BYTES);

   always_comb begin
      state_next = state;
      case (state)
         IDLE, DONE: begin
            if (cmd_wr) begin
               state_next = (cmd_size == '0) ? DONE : FILL;
            end else if (state == DONE && stat_wr) begin
               state_next = IDLE;
            end
         end
         // Four disk reads back to back
         FILL: begin
            if (fill_cnt == BEAT_W'(LINE_BEATS - 1)) begin
               state_next = ST_BR;
            end
         end
         ST_BR: begin
            if (dma_bg) begin
               state_next = MSTR;
            end
         end
         MSTR: state_next = ST_WR;
         ST_WR: begin
            if (bus_ack) begin
               if (!last_beat) begin
                  state_next = MSTR;
               end else if (count_next == '0) begin
                  state_next = DONE;
               end else begin
                  state_next = FILL;
               end
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state     <= IDLE;
         stat_q    <= STAT_IDLE;
         count_q   <= '0;
         src_q     <= '0;
         dst_q     <= '0;
         fill_cnt  <= '0;
         beat_cnt  <= '0;
         load_q    <= 1'b0;
         load_idx  <= '0;
         slave_ack <= 1'b0;
      end else begin
         state     <= state_next;
         slave_ack <= reg_take;

         // Disk data comes back one cycle after the read
         load_q   <= state == FILL;
         load_idx <= fill_cnt;
         if (state == FILL) begin
            fill_cnt <= fill_cnt + 1'b1;
         end

         // Wraps to zero after the last beat of a line
         if (state == ST_WR && bus_ack) begin
            beat_cnt <= beat_cnt + 1'b1;
         end

         if (reg_wr && prog_ok && reg_off == REG_SRC) begin
            src_q <= bus_d[15:0];
         end
         if (reg_wr && prog_ok && reg_off == REG_DST) begin
            dst_q <= bus_d[15:0];
         end

         if (cmd_wr) begin
            count_q <= cmd_size;
            stat_q  <= (cmd_size == '0) ? STAT_DONE : STAT_BUSY;
         end else if (stat_wr && state == DONE) begin
            stat_q <= STAT_IDLE;
         end

         // Line written, move on to the next one
         if (line_end) begin
            count_q <= count_next;
            src_q   <= src_q + bus_addr_t'(LINE_BYTES);
            dst_q   <= dst_q + bus_addr_t'(LINE_BYTES);
            if (count_next == '0) begin
               stat_q <= STAT_DONE;
            end
         end
      end
   end

   // Register read data, valid with slave_ack
   always_ff @(posedge bus_clk) begin
      if (reg_take) begin
         case (reg_off)
            REG_SRC:  slave_rdata <= {16'h0, src_q};
            REG_DST:  slave_rdata <= {16'h0, dst_q};
            REG_CMD:  slave_rdata <= {20'h0, count_q};
            REG_STAT: slave_rdata <= {30'h0, stat_q};
            default:  slave_rdata <= '0;
         endcase
      end
   end

   // Master outputs, the engine only ever writes memory
   assign dma_br     = (state == ST_BR) || (state == MSTR) || (state == ST_WR);
   assign dma_strobe = (state == MSTR) || (state == ST_WR);
   assign dma_a      = dst_q + bus_addr_t'({beat_cnt, 2'b00});
   assign dma_d      = buf_word;
   assign dma_rw     = 1'b1;

   assign disk_en   = state == FILL;
   assign disk_addr = src_q[DISK_AW+1:2] + {{(DISK_AW - BEAT_W){1'b0}}, fill_cnt};

   assign buf_load = load_q;
   assign buf_beat = load_q ? load_idx : beat_cnt;
   assign dma_intr = state == DONE;

endmodule

`default_nettype wire

// ==== dma/dma_line_buffer.sv ====
// 128-bit DMA line buffer, loaded word by word from the disk and read out per bus beat
`timescale 1ns/1ps
`default_nettype none

module dma_line_buffer
   import dma_pkg::*;
(
   input  logic              bus_clk,
   input  logic              reset,
   input  word_t             disk_data,
   input  logic              buf_load,
   input  logic [BEAT_W-1:0] buf_beat,
   output word_t             buf_word
);

   // One full bus line, word 0 in the low bits
   word_t [LINE_BEATS-1:0] line_q;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         line_q <= '0;
      end else if (buf_load) begin
         line_q[buf_beat] <= disk_data;
      end
   end

   // Word for the beat now on the bus
   assign buf_word = line_q[buf_beat];

endmodule

`default_nettype wire

// ==== common/dma_pkg.sv ====
// Shared DMA types, bus map, register offsets, controller state and status encodings
`default_nettype none

package dma_pkg;

   // Bus data, address and transfer size
   typedef logic [31:0] word_t;
   typedef logic [15:0] bus_addr_t;
   typedef logic [11:0] dma_size_t;

   // One bus line is four word beats
   localparam int LINE_BYTES = 16;
   localparam int LINE_BEATS = 4;
   localparam int BEAT_W     = $clog2(LINE_BEATS);

   // Memory answers 0x0000 to 0x0FFF
   localparam int MEM_WORDS = 1024;
   localparam int MEM_AW    = $clog2(MEM_WORDS);

   // Disk image, addressed by word index
   localparam int DISK_WORDS = 1024;
   localparam int DISK_AW    = $clog2(DISK_WORDS);

   // Register window of the controller
   localparam bus_addr_t  DMA_BASE = 16'hF000;
   localparam logic [3:0] REG_SRC  = 4'h0;
   localparam logic [3:0] REG_DST  = 4'h4;
   localparam logic [3:0] REG_CMD  = 4'h8;
   localparam logic [3:0] REG_STAT = 4'hC;

   // Controller FSM
   typedef enum logic [2:0] {
      IDLE,
      FILL,
      ST_BR,
      MSTR,
      ST_WR,
      DONE
   } dma_state_t;

   // Value returned in STAT bits 1:0
   typedef enum logic [1:0] {
      STAT_IDLE = 2'd0,
      STAT_BUSY = 2'd1,
      STAT_DONE = 2'd2
   } dma_status_t;

endpackage

`default_nettype wire
